/* common/system_pkg.sv */
package system_pkg;

	localparam int IO_DEV_COUNT = 16;

	typedef logic [15:0] io_addr_t;
	typedef logic [31:0] io_word_t;
	typedef logic [7:0]  io_byte_t;
	typedef logic [2:0]  io_size_t;
	typedef logic [15:0] mgmt_addr_t;
	typedef logic [15:0] mgmt_word_t;
	typedef logic [7:0]  mgmt_page_t;
	typedef logic [15:0] irq_vec_t;
	typedef logic [7:0]  syscfg_t;

	// one value per external device, used to index the read byte array
	typedef enum logic [$clog2(IO_DEV_COUNT)-1:0] {
		DEV_NONE, DEV_IDE0, DEV_IDE1, DEV_FLOPPY,
		DEV_DMA, DEV_PIC, DEV_PIT, DEV_PS2,
		DEV_RTC, DEV_SOUND, DEV_UART1, DEV_UART2,
		DEV_MPU, DEV_VGA, DEV_JOY, DEV_SYSCTL
	} io_dev_t;

	typedef enum logic [2:0] {MGMT_NONE, MGMT_IDE0, MGMT_IDE1, MGMT_FDD, MGMT_RTC} mgmt_dev_t;

	typedef enum logic {SYSCTL_BOOT, SYSCTL_RUN} sysctl_state_t;

	// a range covers base .. base + 2**bits - 1
	localparam io_addr_t    IDE0_BASE        = 16'h01F0;
	localparam int unsigned IDE0_BASE_BITS   = 3;
	localparam io_addr_t    IDE0_CTRL        = 16'h03F6;
	localparam io_addr_t    IDE1_BASE        = 16'h0170;
	localparam int unsigned IDE1_BASE_BITS   = 3;
	localparam io_addr_t    IDE1_CTRL        = 16'h0376;
	localparam io_addr_t    FLOPPY_BASE      = 16'h03F0;
	localparam int unsigned FLOPPY_BASE_BITS = 2;
	localparam io_addr_t    FLOPPY_FIFO      = 16'h03F4; // status and data pair
	localparam int unsigned FLOPPY_FIFO_BITS = 1;
	localparam io_addr_t    FLOPPY_DIR       = 16'h03F7;
	localparam io_addr_t    DMA_MASTER_BASE  = 16'h00C0;
	localparam int unsigned DMA_MASTER_BITS  = 5;
	localparam io_addr_t    DMA_PAGE_BASE    = 16'h0080;
	localparam int unsigned DMA_PAGE_BITS    = 4;
	localparam io_addr_t    DMA_SLAVE_BASE   = 16'h0000;
	localparam int unsigned DMA_SLAVE_BITS   = 4;
	localparam io_addr_t    PIC_MASTER_BASE  = 16'h0020;
	localparam io_addr_t    PIC_SLAVE_BASE   = 16'h00A0;
	localparam int unsigned PIC_BITS         = 1;
	localparam io_addr_t    PIT_BASE         = 16'h0040;
	localparam int unsigned PIT_BITS         = 2;
	localparam io_addr_t    PIT_SPEAKER      = 16'h0061;
	localparam io_addr_t    PS2_DATA_BASE    = 16'h0060;
	localparam int unsigned PS2_DATA_BITS    = 3;
	localparam io_addr_t    PS2_CTRL_BASE    = 16'h0090;
	localparam int unsigned PS2_CTRL_BITS    = 4;
	localparam io_addr_t    RTC_BASE         = 16'h0070;
	localparam int unsigned RTC_BITS         = 1;
	localparam io_addr_t    SB_BASE          = 16'h0220;
	localparam int unsigned SB_BITS          = 4;
	localparam io_addr_t    FM_BASE          = 16'h0388;
	localparam int unsigned FM_BITS          = 2;
	localparam io_addr_t    UART1_BASE       = 16'h03F8;
	localparam io_addr_t    UART2_BASE       = 16'h02F8;
	localparam int unsigned UART_BITS        = 3;
	localparam io_addr_t    MPU_BASE         = 16'h0330;
	localparam int unsigned MPU_BITS         = 1;
	localparam io_addr_t    VGA_B_BASE       = 16'h03B0;
	localparam io_addr_t    VGA_C_BASE       = 16'h03C0;
	localparam io_addr_t    VGA_D_BASE       = 16'h03D0;
	localparam int unsigned VGA_BITS         = 4;
	localparam io_addr_t    JOY_PORT         = 16'h0201;

	localparam io_addr_t SYSCTL_PORT        = 16'h8888;
	localparam io_byte_t SYSCTL_KEY         = 8'hA1;
	localparam syscfg_t  SYSCTL_RESET_VALUE = 8'hA2;
	localparam io_size_t SYSCTL_WRITE_SIZE  = 3'd2;

	localparam io_byte_t    IO_IDLE_BYTE = 8'hFF;
	localparam int unsigned IDE_CTRL_BIT = 9; // set on 3F6 and 376

	localparam mgmt_page_t MGMT_PAGE_IDE0 = 8'hF0;
	localparam mgmt_page_t MGMT_PAGE_IDE1 = 8'hF1;
	localparam mgmt_page_t MGMT_PAGE_FDD  = 8'hF2;
	localparam mgmt_page_t MGMT_PAGE_RTC  = 8'hF4;

endpackage

/* io_bus/io_decoder.sv */
module io_decoder (
	input  logic                clk_sys,
	input  logic                reset,
	input  system_pkg::io_addr_t io_address,
	output system_pkg::io_dev_t  io_dev
);

	import system_pkg::*;

	io_dev_t dev_next;

	// true when addr falls in the aligned block of 2**bits ports at base
	function automatic logic in_range(io_addr_t addr, io_addr_t base, int unsigned bits);
		return (addr >> bits) == (base >> bits);
	endfunction

	always_comb begin
		dev_next = DEV_NONE;
		if (in_range(io_address, IDE0_BASE, IDE0_BASE_BITS) || io_address == IDE0_CTRL) begin
			dev_next = DEV_IDE0;
		end else if (in_range(io_address, IDE1_BASE, IDE1_BASE_BITS)
				|| io_address == IDE1_CTRL) begin
			dev_next = DEV_IDE1;
		end else if (in_range(io_address, FLOPPY_BASE, FLOPPY_BASE_BITS)
				|| in_range(io_address, FLOPPY_FIFO, FLOPPY_FIFO_BITS)
				|| io_address == FLOPPY_DIR) begin
			dev_next = DEV_FLOPPY;
		end else if (in_range(io_address, DMA_MASTER_BASE, DMA_MASTER_BITS)
				|| in_range(io_address, DMA_PAGE_BASE, DMA_PAGE_BITS)
				|| in_range(io_address, DMA_SLAVE_BASE, DMA_SLAVE_BITS)) begin
			dev_next = DEV_DMA;
		end else if (in_range(io_address, PIC_MASTER_BASE, PIC_BITS)
				|| in_range(io_address, PIC_SLAVE_BASE, PIC_BITS)) begin
			dev_next = DEV_PIC;
		end else if (in_range(io_address, PIT_BASE, PIT_BITS)
				|| io_address == PIT_SPEAKER) begin
			// port 61 also sits inside the keyboard block, the timer owns it
			dev_next = DEV_PIT;
		end else if (in_range(io_address, PS2_DATA_BASE, PS2_DATA_BITS)
				|| in_range(io_address, PS2_CTRL_BASE, PS2_CTRL_BITS)) begin
			dev_next = DEV_PS2;
		end else if (in_range(io_address, RTC_BASE, RTC_BITS)) begin
			dev_next = DEV_RTC;
		end else if (in_range(io_address, SB_BASE, SB_BITS)
				|| in_range(io_address, FM_BASE, FM_BITS)) begin
			dev_next = DEV_SOUND;
		end else if (in_range(io_address, UART1_BASE, UART_BITS)) begin
			dev_next = DEV_UART1;
		end else if (in_range(io_address, UART2_BASE, UART_BITS)) begin
			dev_next = DEV_UART2;
		end else if (in_range(io_address, MPU_BASE, MPU_BITS)) begin
			dev_next = DEV_MPU;
		end else if (in_range(io_address, VGA_B_BASE, VGA_BITS)
				|| in_range(io_address, VGA_C_BASE, VGA_BITS)
				|| in_range(io_address, VGA_D_BASE, VGA_BITS)) begin
			dev_next = DEV_VGA;
		end else if (io_address == JOY_PORT) begin
			dev_next = DEV_JOY;
		end else if (io_address == SYSCTL_PORT) begin
			dev_next = DEV_SYSCTL;
		end
	end

	// the select lags the address by one clock, devices see it with the strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_dev <= DEV_NONE;
		end else begin
			io_dev <= dev_next;
		end
	end

endmodule

/* io_bus/io_read_mux.sv */
module io_read_mux (
	input  system_pkg::io_dev_t  io_dev,
	input  system_pkg::io_addr_t io_address,
	input  system_pkg::io_byte_t dev_readdata [system_pkg::IO_DEV_COUNT],
	input  system_pkg::io_word_t ide0_readdata,
	input  system_pkg::io_word_t ide1_readdata,
	output system_pkg::io_word_t io_readdata,
	output logic                 io_32
);

	import system_pkg::*;

	logic disk_sel;

	always_comb begin
		case (io_dev)
			DEV_IDE0: begin
				io_readdata = ide0_readdata;
			end
			DEV_IDE1: begin
				io_readdata = ide1_readdata;
			end
			DEV_NONE, DEV_SYSCTL: begin
				// nothing drives the bus, the control port is write only
				io_readdata = {24'd0, IO_IDLE_BYTE};
			end
			default: begin
				io_readdata = {24'd0, dev_readdata[io_dev]};
			end
		endcase
	end

	assign disk_sel = (io_dev == DEV_IDE0) || (io_dev == DEV_IDE1);

	// disk task file ports move 32 bits, control ports at 3F6/376 stay byte wide
	assign io_32 = (disk_sel && !io_address[IDE_CTRL_BIT]) || (io_dev == DEV_SYSCTL);

endmodule

/* verilog/ide_wait.sv */
module ide_wait (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  system_pkg::io_dev_t  io_dev,
	input  system_pkg::io_addr_t io_address,
	input  logic                 io_read,
	input  logic [1:0]           ide_nodata,
	output logic [1:0]           ide_read,
	output logic                 io_wait
);

	import system_pkg::*;

	logic [1:0] chan_sel;
	logic [1:0] set_wait;
	logic [1:0] wait_flag;
	logic       data_port;

	assign chan_sel = {io_dev == DEV_IDE1, io_dev == DEV_IDE0};

	// offset zero of the task file, the control block is excluded by bit 9
	assign data_port = ({io_address[IDE_CTRL_BIT], io_address[2:0]} == 4'd0);

	assign set_wait = chan_sel & ide_nodata & {2{io_read & data_port}};

	// a flag stays up until its channel has data again
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wait_flag <= 2'b00;
		end else begin
			wait_flag <= (wait_flag | set_wait) & ide_nodata;
		end
	end

	// keep reading the channel while stalled so it can fetch the next word
	assign ide_read = (chan_sel & {2{io_read}}) | wait_flag;
	assign io_wait  = |wait_flag;

endmodule

/* verilog/sysctl_port.sv */
module sysctl_port (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  system_pkg::io_dev_t  io_dev,
	input  logic                 io_write,
	input  system_pkg::io_size_t io_datasize,
	input  system_pkg::io_word_t io_writedata,
	output system_pkg::syscfg_t  syscfg
);

	import system_pkg::*;

	sysctl_state_t state;
	logic          boot_access;
	logic          key_write;

	// first touch of a disk or floppy means the loader has taken over
	assign boot_access = (io_dev == DEV_IDE0) || (io_dev == DEV_IDE1)
		|| (io_dev == DEV_FLOPPY);

	assign key_write = io_write && (io_dev == DEV_SYSCTL)
		&& (io_datasize == SYSCTL_WRITE_SIZE)
		&& (io_writedata[15:8] == SYSCTL_KEY); // high byte unlocks the register

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= SYSCTL_BOOT;
			syscfg <= SYSCTL_RESET_VALUE;
		end else begin
			case (state)
				SYSCTL_BOOT: begin
					if (boot_access) begin
						syscfg <= '0;
						state  <= SYSCTL_RUN;
					end else if (key_write) begin
						syscfg <= io_writedata[7:0];
						state  <= SYSCTL_RUN;
					end
				end
				default: begin
					if (key_write) begin
						syscfg <= io_writedata[7:0];
					end
				end
			endcase
		end
	end

endmodule

/* verilog/mgmt_decoder.sv */
module mgmt_decoder (
	input  system_pkg::mgmt_addr_t mgmt_address,
	input  logic                   mgmt_read,
	input  logic                   mgmt_write,
	input  system_pkg::mgmt_word_t mgmt_ide0_readdata,
	input  system_pkg::mgmt_word_t mgmt_ide1_readdata,
	input  system_pkg::mgmt_word_t mgmt_fdd_readdata,
	output system_pkg::mgmt_dev_t  mgmt_target,
	output logic                   mgmt_rd_strobe,
	output logic                   mgmt_wr_strobe,
	output system_pkg::mgmt_word_t mgmt_readdata
);

	import system_pkg::*;

	mgmt_page_t page;
	logic       target_valid;

	assign page = mgmt_address[15:8]; // low byte is the register inside the target

	always_comb begin
		case (page)
			MGMT_PAGE_IDE0: mgmt_target = MGMT_IDE0;
			MGMT_PAGE_IDE1: mgmt_target = MGMT_IDE1;
			MGMT_PAGE_FDD:  mgmt_target = MGMT_FDD;
			MGMT_PAGE_RTC:  mgmt_target = MGMT_RTC;
			default:        mgmt_target = MGMT_NONE;
		endcase
	end

	assign target_valid   = (mgmt_target != MGMT_NONE);
	assign mgmt_rd_strobe = mgmt_read & target_valid;
	assign mgmt_wr_strobe = mgmt_write & target_valid;

	// the RTC is write only here, so it falls through to the floppy data
	assign mgmt_readdata = (mgmt_target == MGMT_IDE0) ? mgmt_ide0_readdata :
		(mgmt_target == MGMT_IDE1) ? mgmt_ide1_readdata : mgmt_fdd_readdata;

endmodule

/* verilog/system_io.sv */
module system_io (
	input  logic                   clk_sys,
	input  logic                   reset,

	input  system_pkg::io_addr_t   io_address,
	input  logic                   io_read,
	input  logic                   io_write,
	input  system_pkg::io_size_t   io_datasize,
	input  system_pkg::io_word_t   io_writedata,
	output system_pkg::io_dev_t    io_dev,
	output system_pkg::io_word_t   io_readdata,
	output logic                   io_32,
	output logic                   io_wait,

	input  system_pkg::io_byte_t   dev_readdata [system_pkg::IO_DEV_COUNT],
	input  system_pkg::io_word_t   ide0_readdata,
	input  system_pkg::io_word_t   ide1_readdata,
	input  logic [1:0]             ide_nodata,
	output logic [1:0]             ide_read,

	output system_pkg::syscfg_t    syscfg,

	input  system_pkg::irq_vec_t   irq_in,
	output system_pkg::irq_vec_t   irq_lines,

	input  system_pkg::mgmt_addr_t mgmt_address,
	input  logic                   mgmt_read,
	input  logic                   mgmt_write,
	input  system_pkg::mgmt_word_t mgmt_ide0_readdata,
	input  system_pkg::mgmt_word_t mgmt_ide1_readdata,
	input  system_pkg::mgmt_word_t mgmt_fdd_readdata,
	output system_pkg::mgmt_dev_t  mgmt_target,
	output logic                   mgmt_rd_strobe,
	output logic                   mgmt_wr_strobe,
	output system_pkg::mgmt_word_t mgmt_readdata
);

	io_decoder u_io_decoder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_address (io_address),
		.io_dev     (io_dev)
	);

	io_read_mux u_io_read_mux (
		.io_dev        (io_dev),
		.io_address    (io_address),
		.dev_readdata  (dev_readdata),
		.ide0_readdata (ide0_readdata),
		.ide1_readdata (ide1_readdata),
		.io_readdata   (io_readdata),
		.io_32         (io_32)
	);

	ide_wait u_ide_wait (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_dev     (io_dev),
		.io_address (io_address),
		.io_read    (io_read),
		.ide_nodata (ide_nodata),
		.ide_read   (ide_read),
		.io_wait    (io_wait)
	);

	sysctl_port u_sysctl_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.io_dev       (io_dev),
		.io_write     (io_write),
		.io_datasize  (io_datasize),
		.io_writedata (io_writedata),
		.syscfg       (syscfg)
	);

	mgmt_decoder u_mgmt_decoder (
		.mgmt_address       (mgmt_address),
		.mgmt_read          (mgmt_read),
		.mgmt_write         (mgmt_write),
		.mgmt_ide0_readdata (mgmt_ide0_readdata),
		.mgmt_ide1_readdata (mgmt_ide1_readdata),
		.mgmt_fdd_readdata  (mgmt_fdd_readdata),
		.mgmt_target        (mgmt_target),
		.mgmt_rd_strobe     (mgmt_rd_strobe),
		.mgmt_wr_strobe     (mgmt_wr_strobe),
		.mgmt_readdata      (mgmt_readdata)
	);

	// line 2 is the cascade input on a PC, its sources are redirected to 9
	always_comb begin
		irq_lines     = irq_in;
		irq_lines[9]  = irq_in[9] | irq_in[2];
		irq_lines[2]  = 1'b0;
		irq_lines[11] = 1'b0; // no source on 11 and 13
		irq_lines[13] = 1'b0;
	end

endmodule

/* sim/system_io_checker.sv */
module system_io_checker (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  system_pkg::io_dev_t    io_dev,
	input  system_pkg::io_word_t   io_readdata,
	input  logic                   io_32,
	input  logic                   io_wait,
	input  logic [1:0]             ide_read,
	input  system_pkg::syscfg_t    syscfg,
	input  system_pkg::irq_vec_t   irq_in,
	input  system_pkg::irq_vec_t   irq_lines,
	input  system_pkg::mgmt_addr_t mgmt_address,
	input  logic                   mgmt_read,
	input  logic                   mgmt_write,
	input  system_pkg::mgmt_word_t mgmt_ide0_readdata,
	input  system_pkg::mgmt_word_t mgmt_ide1_readdata,
	input  system_pkg::mgmt_word_t mgmt_fdd_readdata,
	input  system_pkg::mgmt_dev_t  mgmt_target,
	input  logic                   mgmt_rd_strobe,
	input  logic                   mgmt_wr_strobe,
	input  system_pkg::mgmt_word_t mgmt_readdata,
	input  logic                   chk_rd,
	input  system_pkg::io_dev_t    exp_dev,
	input  system_pkg::io_word_t   exp_readdata,
	input  logic                   exp_io32,
	input  logic                   chk_cfg,
	input  system_pkg::syscfg_t    exp_syscfg,
	input  logic                   chk_wait,
	input  logic                   exp_wait,
	output int                     check_count,
	output int                     error_count
);

	timeunit 1ns;
	timeprecision 100ps;

	import system_pkg::*;

	mgmt_dev_t exp_target;

	initial begin
		check_count = 0;
		error_count = 0;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// lines 2, 11 and 13 are dropped, and the cascade source moves to line 9
	function automatic irq_vec_t routed_irq(irq_vec_t src);
		return (src & ~16'h2804) | (irq_vec_t'(src[2]) << 9);
	endfunction

	function automatic mgmt_dev_t target_for_page(logic [7:0] page);
		case (page)
			8'hF0:   return MGMT_IDE0;
			8'hF1:   return MGMT_IDE1;
			8'hF2:   return MGMT_FDD;
			8'hF4:   return MGMT_RTC;
			default: return MGMT_NONE;
		endcase
	endfunction

	function automatic mgmt_word_t mgmt_data_for(mgmt_dev_t target);
		if (target == MGMT_IDE0)
			return mgmt_ide0_readdata;
		if (target == MGMT_IDE1)
			return mgmt_ide1_readdata;
		return mgmt_fdd_readdata; // every other page reads the floppy word
	endfunction

	// inputs change on the falling edge, so everything is settled here
	always @(posedge clk_sys) begin
		if (!reset) begin
			compare_value("irq_lines", irq_lines, routed_irq(irq_in));
			exp_target = target_for_page(mgmt_address[15:8]);
			compare_value("mgmt_target", mgmt_target, exp_target);
			compare_value("mgmt_rd_strobe", mgmt_rd_strobe,
				mgmt_read && (exp_target != MGMT_NONE));
			compare_value("mgmt_wr_strobe", mgmt_wr_strobe,
				mgmt_write && (exp_target != MGMT_NONE));
			compare_value("mgmt_readdata", mgmt_readdata, mgmt_data_for(exp_target));
			if (chk_rd) begin
				compare_value("io_dev", io_dev, exp_dev);
				compare_value("io_readdata", io_readdata, exp_readdata);
				compare_value("io_32", io_32, exp_io32);
			end
			if (chk_cfg)
				compare_value("syscfg", syscfg, exp_syscfg);
			if (chk_wait) begin
				compare_value("io_wait", io_wait, exp_wait);
				// only channel 0 is ever stalled, and the strobe is gone by now
				compare_value("ide_read", ide_read, {1'b0, exp_wait});
			end
		end
	end

endmodule

/* sim/tb_system_io.sv */
module tb_system_io;

	timeunit 1ns;
	timeprecision 100ps;

	import system_pkg::*;

	localparam int unsigned SEED      = 32'h7a06ab79;
	localparam io_word_t    IDE0_WORD = 32'hC0DE_1DE0;
	localparam io_word_t    IDE1_WORD = 32'hC0DE_1DE1;

	typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_MGMT, OP_IRQ, OP_RELEASE} op_t;

	typedef struct packed {
		op_t        op;
		io_addr_t   addr;
		io_size_t   size;
		io_word_t   wdata;
		logic [1:0] nodata;
		io_dev_t    exp_dev;
		io_word_t   exp_data;
		logic       exp_io32;
		syscfg_t    exp_cfg;
		logic       exp_wait;
	} row_t;

	row_t rows[$];
	logic table_ready = 1'b0;

	logic       clk_sys;
	logic       reset;
	io_addr_t   io_address;
	logic       io_read;
	logic       io_write;
	io_size_t   io_datasize;
	io_word_t   io_writedata;
	io_dev_t    io_dev;
	io_word_t   io_readdata;
	logic       io_32;
	logic       io_wait;
	io_byte_t   dev_readdata [IO_DEV_COUNT];
	io_word_t   ide0_readdata;
	io_word_t   ide1_readdata;
	logic [1:0] ide_nodata;
	logic [1:0] ide_read;
	syscfg_t    syscfg;
	irq_vec_t   irq_in;
	irq_vec_t   irq_lines;
	mgmt_addr_t mgmt_address;
	logic       mgmt_read;
	logic       mgmt_write;
	mgmt_word_t mgmt_ide0_readdata;
	mgmt_word_t mgmt_ide1_readdata;
	mgmt_word_t mgmt_fdd_readdata;
	mgmt_dev_t  mgmt_target;
	logic       mgmt_rd_strobe;
	logic       mgmt_wr_strobe;
	mgmt_word_t mgmt_readdata;

	logic     chk_rd;
	logic     chk_cfg;
	logic     chk_wait;
	io_dev_t  exp_dev;
	io_word_t exp_readdata;
	logic     exp_io32;
	syscfg_t  exp_syscfg;
	logic     exp_wait;
	int       check_count;
	int       error_count;

	system_io UUT (.*);

	system_io_checker scoreboard (.*);

	always #2 clk_sys = ~clk_sys;

	task automatic add_row(input op_t op, input io_addr_t addr, input io_size_t size,
			input io_word_t wdata, input logic [1:0] nodata, input io_dev_t dev,
			input io_word_t exp_data, input logic exp_io32_v, input syscfg_t exp_cfg,
			input logic exp_wait_v);
		rows.push_back({op, addr, size, wdata, nodata, dev, exp_data, exp_io32_v, exp_cfg,
			exp_wait_v});
	endtask

	// entered and left on a falling edge
	task automatic apply_row(input row_t r);
		case (r.op)
			OP_READ, OP_WRITE: begin
				io_address   = r.addr; // the select follows one edge later
				io_datasize  = r.size;
				io_writedata = r.wdata;
				ide_nodata   = r.nodata;
				@(negedge clk_sys);
				io_read      = (r.op == OP_READ);
				io_write     = (r.op == OP_WRITE);
				exp_dev      = r.exp_dev;
				exp_readdata = r.exp_data;
				exp_io32     = r.exp_io32;
				chk_rd       = 1'b1;
				@(negedge clk_sys);
				io_read    = 1'b0;
				io_write   = 1'b0;
				chk_rd     = 1'b0;
				exp_syscfg = r.exp_cfg;
				exp_wait   = r.exp_wait;
				chk_cfg    = 1'b1;
				chk_wait   = 1'b1;
				@(negedge clk_sys);
				chk_cfg  = 1'b0;
				chk_wait = 1'b0;
			end
			OP_RELEASE: begin
				io_address = r.addr;
				ide_nodata = r.nodata;
				@(negedge clk_sys);
				exp_wait = r.exp_wait;
				chk_wait = 1'b1;
				@(negedge clk_sys);
				chk_wait = 1'b0;
			end
			OP_MGMT: begin
				mgmt_address = r.addr;
				// read only, write only, then both strobes on every page
				for (int k = 1; k < 4; k++) begin
					mgmt_read          = k[0];
					mgmt_write         = k[1];
					mgmt_ide0_readdata = mgmt_word_t'($urandom);
					mgmt_ide1_readdata = mgmt_word_t'($urandom);
					mgmt_fdd_readdata  = mgmt_word_t'($urandom);
					@(negedge clk_sys);
				end
			end
			default: begin
				repeat (3) begin
					irq_in = irq_vec_t'($urandom);
					@(negedge clk_sys);
				end
			end
		endcase
	endtask

	initial begin
		void'($urandom(SEED));
		clk_sys      = 1'b0;
		reset        = 1'b1;
		io_address   = '0;
		io_read      = 1'b0;
		io_write     = 1'b0;
		io_datasize  = '0;
		io_writedata = '0;
		for (int i = 0; i < IO_DEV_COUNT; i++)
			dev_readdata[i] = io_byte_t'(8'h40 + i);
		ide0_readdata      = IDE0_WORD;
		ide1_readdata      = IDE1_WORD;
		ide_nodata         = 2'b00;
		irq_in             = '0;
		mgmt_address       = '0;
		mgmt_read          = 1'b0;
		mgmt_write         = 1'b0;
		mgmt_ide0_readdata = '0;
		mgmt_ide1_readdata = '0;
		mgmt_fdd_readdata  = '0;
		chk_rd       = 1'b0;
		chk_cfg      = 1'b0;
		chk_wait     = 1'b0;
		exp_dev      = DEV_NONE;
		exp_readdata = '0;
		exp_io32     = 1'b0;
		exp_syscfg   = '0;
		exp_wait     = 1'b0;

		// op, address, size, write data, nodata, device, read word, io_32, syscfg, io_wait
		add_row(OP_READ, 16'h0300, 3'd1, 32'h0, 2'b00, DEV_NONE, 32'hFF, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h00C0, 3'd1, 32'h0, 2'b00, DEV_DMA, 32'h44, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h0020, 3'd1, 32'h0, 2'b00, DEV_PIC, 32'h45, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h0040, 3'd1, 32'h0, 2'b00, DEV_PIT, 32'h46, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h0060, 3'd1, 32'h0, 2'b00, DEV_PS2, 32'h47, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h0070, 3'd1, 32'h0, 2'b00, DEV_RTC, 32'h48, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h0220, 3'd1, 32'h0, 2'b00, DEV_SOUND, 32'h49, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h03F8, 3'd1, 32'h0, 2'b00, DEV_UART1, 32'h4A, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h02F8, 3'd1, 32'h0, 2'b00, DEV_UART2, 32'h4B, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h0330, 3'd1, 32'h0, 2'b00, DEV_MPU, 32'h4C, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h03C0, 3'd1, 32'h0, 2'b00, DEV_VGA, 32'h4D, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h0201, 3'd1, 32'h0, 2'b00, DEV_JOY, 32'h4E, 1'b0, 8'hA2, 1'b0);
		add_row(OP_READ, 16'h03F0, 3'd1, 32'h0, 2'b00, DEV_FLOPPY, 32'h43, 1'b0, 8'h00, 1'b0);
		add_row(OP_READ, 16'h01F0, 3'd4, 32'h0, 2'b00, DEV_IDE0, IDE0_WORD, 1'b1, 8'h00, 1'b0);
		add_row(OP_WRITE, 16'h8888, 3'd2, 32'hA155, 2'b00, DEV_SYSCTL, 32'hFF, 1'b1, 8'h55, 1'b0);
		add_row(OP_WRITE, 16'h8888, 3'd2, 32'hA077, 2'b00, DEV_SYSCTL, 32'hFF, 1'b1, 8'h55, 1'b0);
		add_row(OP_WRITE, 16'h8888, 3'd1, 32'hA133, 2'b00, DEV_SYSCTL, 32'hFF, 1'b1, 8'h55, 1'b0);
		add_row(OP_READ, 16'h8888, 3'd2, 32'h0, 2'b00, DEV_SYSCTL, 32'hFF, 1'b1, 8'h55, 1'b0);
		add_row(OP_READ, 16'h0170, 3'd4, 32'h0, 2'b00, DEV_IDE1, IDE1_WORD, 1'b1, 8'h55, 1'b0);
		add_row(OP_READ, 16'h03F6, 3'd1, 32'h0, 2'b00, DEV_IDE0, IDE0_WORD, 1'b0, 8'h55, 1'b0);
		add_row(OP_READ, 16'h01F0, 3'd4, 32'h0, 2'b01, DEV_IDE0, IDE0_WORD, 1'b1, 8'h55, 1'b1);
		add_row(OP_RELEASE, 16'h01F0, 3'd4, 32'h0, 2'b00, DEV_IDE0, 32'h0, 1'b0, 8'h00, 1'b0);
		repeat (4)
			add_row(OP_IRQ, 16'h0, 3'd0, 32'h0, 2'b00, DEV_NONE, 32'h0, 1'b0, 8'h00, 1'b0);
		add_row(OP_MGMT, 16'hF012, 3'd0, 32'h0, 2'b00, DEV_NONE, 32'h0, 1'b0, 8'h00, 1'b0);
		add_row(OP_MGMT, 16'hF134, 3'd0, 32'h0, 2'b00, DEV_NONE, 32'h0, 1'b0, 8'h00, 1'b0);
		add_row(OP_MGMT, 16'hF256, 3'd0, 32'h0, 2'b00, DEV_NONE, 32'h0, 1'b0, 8'h00, 1'b0);
		add_row(OP_MGMT, 16'hF478, 3'd0, 32'h0, 2'b00, DEV_NONE, 32'h0, 1'b0, 8'h00, 1'b0);
		add_row(OP_MGMT, 16'hF39A, 3'd0, 32'h0, 2'b00, DEV_NONE, 32'h0, 1'b0, 8'h00, 1'b0);
		add_row(OP_MGMT, 16'h12BC, 3'd0, 32'h0, 2'b00, DEV_NONE, 32'h0, 1'b0, 8'h00, 1'b0);
		table_ready = 1'b1;

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		foreach (rows[i])
			apply_row(rows[i]);
		repeat (2) @(negedge clk_sys);

		$display("closing: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// each row takes at most 3 cycles and 8 per row leaves room for reset
	initial begin
		wait (table_ready);
		#((rows.size() * 8 + 16) * 4);
		$display("timeout: the stimulus table did not finish in time");
		$display("closing: %0d checks, %0d errors", check_count, error_count);
		$display("Done: errors found");
		$finish;
	end

endmodule

/* system_io.f */
common/system_pkg.sv
io_bus/io_decoder.sv
io_bus/io_read_mux.sv
verilog/ide_wait.sv
verilog/sysctl_port.sv
verilog/mgmt_decoder.sv
verilog/system_io.sv
sim/system_io_checker.sv
sim/tb_system_io.sv
